// File: axi2iob_macros.svh
/*
 * AXI4 to IOb bridge widths
 * address, data, strobe, ID and burst length sizes shared by every block
 */
`ifndef AXI2IOB_MACROS_SVH
`define AXI2IOB_MACROS_SVH

// byte address with one IOb word per beat
`define AXI2IOB_ADDR_W 32
`define AXI2IOB_DATA_W 32

// one strobe bit per data byte
`define AXI2IOB_STRB_W (`AXI2IOB_DATA_W / 8)

`define AXI2IOB_ID_W 8

// AXI4 burst length field holds beats minus one
`define AXI2IOB_LEN_W 8

`endif

// File: axi2iob_pkg.sv
/*
 * AXI4 to IOb bridge types
 * channel payloads for the AXI side and request words for the IOb side
 */
`default_nettype none
`include "axi2iob_macros.svh"

package axi2iob_pkg;

   // burst command, used for both AW and AR
   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0]   id;
      logic [`AXI2IOB_ADDR_W-1:0] addr;
      logic [`AXI2IOB_LEN_W-1:0]  len;
      logic [2:0]                 size;
   } axi_aw_t;

   typedef struct packed {
      logic [`AXI2IOB_DATA_W-1:0] data;
      logic [`AXI2IOB_STRB_W-1:0] strb;
      logic                       last;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0] id;
   } axi_b_t;

   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0]   id;
      logic [`AXI2IOB_DATA_W-1:0] data;
      logic                       last;
   } axi_r_t;

   // single-word IOb access where a zero strobe marks a read
   typedef struct packed {
      logic [`AXI2IOB_ADDR_W-1:0] addr;
      logic [`AXI2IOB_DATA_W-1:0] wdata;
      logic [`AXI2IOB_STRB_W-1:0] wstrb;
   } iob_req_t;

   typedef logic [`AXI2IOB_DATA_W-1:0] iob_rdata_t;

endpackage

`default_nettype wire

// File: axi2iob_write_burst.sv
/*
 * AXI4 write burst peer
 * splits one incrementing write burst into IOb writes, then returns one B
 */
`timescale 1ns/1ns
`default_nettype none
`include "axi2iob_macros.svh"

module axi2iob_write_burst (
   input  wire                       clk_i,
   input  wire                       arst_i,
   input  wire axi2iob_pkg::axi_aw_t aw_i,
   input  wire                       aw_valid_i,
   output logic                      aw_ready_o,
   input  wire axi2iob_pkg::axi_w_t  w_i,
   input  wire                       w_valid_i,
   output logic                      w_ready_o,
   output axi2iob_pkg::axi_b_t       b_o,
   output logic                      b_valid_o,
   input  wire                       b_ready_i,
   output axi2iob_pkg::iob_req_t     req_o,
   output logic                      req_valid_o,
   input  wire                       accept_i
);
   import axi2iob_pkg::*;

   localparam int ADDR_W = `AXI2IOB_ADDR_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DATA,
      ST_WAIT
   } state_t;

   state_t                    state_q;
   logic                      aw_ready_q;
   logic                      b_valid_q;
   logic [`AXI2IOB_ID_W-1:0]  id_q;
   logic [ADDR_W-1:0]         addr_q;
   logic [2:0]                size_q;
   logic [`AXI2IOB_LEN_W-1:0] count_q;
   iob_req_t                  req_q;

   logic                      aw_hs;
   logic                      w_hs;
   logic                      w_skip;
   logic                      last_beat;
   logic [ADDR_W-1:0]         next_addr;

   assign aw_hs     = aw_ready_q & aw_valid_i;
   assign w_hs      = (state_q == ST_DATA) & w_valid_i;
   // beats without strobes never reach the IOb bus
   assign w_skip    = w_hs & ~(|w_i.strb);
   assign last_beat = (count_q == '0);
   assign next_addr = addr_q + (ADDR_W'(1) << size_q);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= ST_IDLE;
         aw_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
      end else begin
         if (b_valid_q && b_ready_i) begin
            b_valid_q <= 1'b0;
         end
         case (state_q)
            ST_IDLE: begin
               if (aw_hs) begin
                  aw_ready_q <= 1'b0;
                  state_q    <= ST_DATA;
               end else if (!b_valid_q || b_ready_i) begin
                  // next burst only once the previous B is gone
                  aw_ready_q <= 1'b1;
               end
            end
            ST_DATA: begin
               if (w_hs && |w_i.strb) begin
                  state_q <= ST_WAIT;
               end else if (w_skip && last_beat) begin
                  b_valid_q <= 1'b1;
                  state_q   <= ST_IDLE;
               end
            end
            ST_WAIT: begin
               if (accept_i) begin
                  if (last_beat) begin
                     b_valid_q <= 1'b1;
                     state_q   <= ST_IDLE;
                  end else begin
                     state_q <= ST_DATA;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // burst context and the pending IOb write
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q    <= aw_i.id;
         addr_q  <= aw_i.addr;
         size_q  <= aw_i.size;
         count_q <= aw_i.len;
      end
      if (w_hs) begin
         req_q <= '{addr: addr_q, wdata: w_i.data, wstrb: w_i.strb};
      end
      if (w_skip || (state_q == ST_WAIT && accept_i)) begin
         addr_q  <= next_addr;
         count_q <= count_q - 1'b1;
      end
   end

   assign aw_ready_o  = aw_ready_q;
   assign w_ready_o   = (state_q == ST_DATA);
   assign b_valid_o   = b_valid_q;
   assign b_o.id      = id_q;
   assign req_o       = req_q;
   assign req_valid_o = (state_q == ST_WAIT);

endmodule

`default_nettype wire

// File: axi2iob_read_burst.sv
/*
 * AXI4 read burst peer
 * issues one IOb read per beat and presents each word as an R beat
 */
`timescale 1ns/1ns
`default_nettype none
`include "axi2iob_macros.svh"

module axi2iob_read_burst (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire axi2iob_pkg::axi_aw_t    ar_i,
   input  wire                          ar_valid_i,
   output logic                         ar_ready_o,
   output axi2iob_pkg::axi_r_t          r_o,
   output logic                         r_valid_o,
   input  wire                          r_ready_i,
   output axi2iob_pkg::iob_req_t        req_o,
   output logic                         req_valid_o,
   input  wire                          accept_i,
   input  wire                          rvalid_i,
   input  wire axi2iob_pkg::iob_rdata_t rdata_i
);
   import axi2iob_pkg::*;

   localparam int ADDR_W = `AXI2IOB_ADDR_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT,
      ST_BEAT
   } state_t;

   state_t                    state_q;
   logic                      ar_ready_q;
   logic [`AXI2IOB_ID_W-1:0]  id_q;
   logic [ADDR_W-1:0]         addr_q;
   logic [2:0]                size_q;
   logic [`AXI2IOB_LEN_W-1:0] count_q;
   axi_r_t                    r_q;

   logic                      ar_hs;
   logic [ADDR_W-1:0]         next_addr;

   assign ar_hs     = ar_ready_q & ar_valid_i;
   assign next_addr = addr_q + (ADDR_W'(1) << size_q);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= ST_IDLE;
         ar_ready_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (ar_hs) begin
                  ar_ready_q <= 1'b0;
                  state_q    <= ST_REQ;
               end else begin
                  ar_ready_q <= 1'b1;
               end
            end
            ST_REQ: if (accept_i) state_q <= ST_WAIT;
            ST_WAIT: if (rvalid_i) state_q <= ST_BEAT;
            ST_BEAT: begin
               // the next read waits until this beat is taken
               if (r_ready_i) begin
                  state_q <= r_q.last ? ST_IDLE : ST_REQ;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q    <= ar_i.id;
         addr_q  <= ar_i.addr;
         size_q  <= ar_i.size;
         count_q <= ar_i.len;
      end
      if (state_q == ST_REQ && accept_i) begin
         addr_q <= next_addr;
      end
      if (state_q == ST_WAIT && rvalid_i) begin
         r_q     <= '{id: id_q, data: rdata_i, last: (count_q == '0)};
         count_q <= count_q - 1'b1;
      end
   end

   assign ar_ready_o  = ar_ready_q;
   assign r_o         = r_q;
   assign r_valid_o   = (state_q == ST_BEAT);
   // reads carry no strobes and no write data
   assign req_o       = '{addr: addr_q, wdata: '0, wstrb: '0};
   assign req_valid_o = (state_q == ST_REQ);

endmodule

`default_nettype wire

// File: iob_bus_arbiter.sv
/*
 * IOb manager port arbiter
 * shares one IOb port between the write and read peers, alternating on contention
 */
`timescale 1ns/1ns
`default_nettype none

module iob_bus_arbiter (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire axi2iob_pkg::iob_req_t   wr_req_i,
   input  wire                          wr_valid_i,
   output logic                         wr_accept_o,
   input  wire axi2iob_pkg::iob_req_t   rd_req_i,
   input  wire                          rd_valid_i,
   output logic                         rd_accept_o,
   output logic                         rd_rvalid_o,
   output axi2iob_pkg::iob_rdata_t      rd_rdata_o,
   output axi2iob_pkg::iob_req_t        iob_req_o,
   output logic                         iob_valid_o,
   input  wire                          iob_ready_i,
   input  wire                          iob_rvalid_i,
   input  wire axi2iob_pkg::iob_rdata_t iob_rdata_i
);

   logic grant_valid_q;
   logic grant_rd_q;
   logic last_rd_q;
   logic rd_pending_q;

   logic rd_elig;
   logic pick_rd;
   logic sel_rd;
   logic accept;

   // a second read waits until the first one has returned its data
   assign rd_elig = rd_valid_i & ~rd_pending_q;

   // on contention the peer that lost last time goes first
   assign pick_rd = rd_elig & (~wr_valid_i | ~last_rd_q);
   assign sel_rd  = grant_valid_q ? grant_rd_q : pick_rd;

   assign iob_valid_o = sel_rd ? rd_elig : wr_valid_i;
   assign iob_req_o   = sel_rd ? rd_req_i : wr_req_i;
   assign accept      = iob_valid_o & iob_ready_i;
   assign wr_accept_o = accept & ~sel_rd;
   assign rd_accept_o = accept & sel_rd;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         grant_valid_q <= 1'b0;
         grant_rd_q    <= 1'b0;
         last_rd_q     <= 1'b0;
      end else if (accept) begin
         grant_valid_q <= 1'b0;
         last_rd_q     <= sel_rd;
      end else if (iob_valid_o && !grant_valid_q) begin
         // stalled request keeps the bus until it is taken
         grant_valid_q <= 1'b1;
         grant_rd_q    <= sel_rd;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_pending_q <= 1'b0;
      end else if (rd_accept_o) begin
         rd_pending_q <= 1'b1;
      end else if (iob_rvalid_i) begin
         rd_pending_q <= 1'b0;
      end
   end

   // writes return nothing, so rvalid only belongs to an outstanding read
   assign rd_rvalid_o = iob_rvalid_i & rd_pending_q;
   assign rd_rdata_o  = iob_rdata_i;

endmodule

`default_nettype wire

// File: axi2iob_top.sv
/*
 * AXI4 to IOb bridge
 * write and read burst peers sharing one IOb manager port
 */
`timescale 1ns/1ns
`default_nettype none

module axi2iob_top (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire axi2iob_pkg::axi_aw_t    aw_i,
   input  wire                          aw_valid_i,
   output logic                         aw_ready_o,
   input  wire axi2iob_pkg::axi_w_t     w_i,
   input  wire                          w_valid_i,
   output logic                         w_ready_o,
   output axi2iob_pkg::axi_b_t          b_o,
   output logic                         b_valid_o,
   input  wire                          b_ready_i,
   input  wire axi2iob_pkg::axi_aw_t    ar_i,
   input  wire                          ar_valid_i,
   output logic                         ar_ready_o,
   output axi2iob_pkg::axi_r_t          r_o,
   output logic                         r_valid_o,
   input  wire                          r_ready_i,
   output axi2iob_pkg::iob_req_t        iob_req_o,
   output logic                         iob_valid_o,
   input  wire                          iob_ready_i,
   input  wire                          iob_rvalid_i,
   input  wire axi2iob_pkg::iob_rdata_t iob_rdata_i
);
   import axi2iob_pkg::*;

   // peer to arbiter links
   iob_req_t   wr_req;
   logic       wr_valid;
   logic       wr_accept;
   iob_req_t   rd_req;
   logic       rd_valid;
   logic       rd_accept;
   logic       rd_rvalid;
   iob_rdata_t rd_rdata;

   axi2iob_write_burst write0 (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .aw_i       (aw_i),
      .aw_valid_i (aw_valid_i),
      .aw_ready_o (aw_ready_o),
      .w_i        (w_i),
      .w_valid_i  (w_valid_i),
      .w_ready_o  (w_ready_o),
      .b_o        (b_o),
      .b_valid_o  (b_valid_o),
      .b_ready_i  (b_ready_i),
      .req_o      (wr_req),
      .req_valid_o(wr_valid),
      .accept_i   (wr_accept)
   );

   axi2iob_read_burst read0 (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .ar_i       (ar_i),
      .ar_valid_i (ar_valid_i),
      .ar_ready_o (ar_ready_o),
      .r_o        (r_o),
      .r_valid_o  (r_valid_o),
      .r_ready_i  (r_ready_i),
      .req_o      (rd_req),
      .req_valid_o(rd_valid),
      .accept_i   (rd_accept),
      .rvalid_i   (rd_rvalid),
      .rdata_i    (rd_rdata)
   );

   iob_bus_arbiter arb0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .wr_req_i    (wr_req),
      .wr_valid_i  (wr_valid),
      .wr_accept_o (wr_accept),
      .rd_req_i    (rd_req),
      .rd_valid_i  (rd_valid),
      .rd_accept_o (rd_accept),
      .rd_rvalid_o (rd_rvalid),
      .rd_rdata_o  (rd_rdata),
      .iob_req_o   (iob_req_o),
      .iob_valid_o (iob_valid_o),
      .iob_ready_i (iob_ready_i),
      .iob_rvalid_i(iob_rvalid_i),
      .iob_rdata_i (iob_rdata_i)
   );

endmodule

`default_nettype wire

// File: tb_iob_mem.sv
/*
 * IOb subordinate memory model
 * word array with strobe-merged writes and read data one cycle after accept
 */
`timescale 1ns/1ns
`default_nettype none
`include "axi2iob_macros.svh"

module tb_iob_mem #(
   parameter int DEPTH = 1024
) (
   input  wire                          clk_i,
   input  wire                          arst_i,
   input  wire                          ready_i,
   input  wire axi2iob_pkg::iob_req_t   iob_req_i,
   input  wire                          iob_valid_i,
   output logic                         iob_ready_o,
   output logic                         iob_rvalid_o,
   output axi2iob_pkg::iob_rdata_t      iob_rdata_o
);
   import axi2iob_pkg::*;

   localparam int IDX_W = $clog2(DEPTH);

   logic [`AXI2IOB_DATA_W-1:0] words [DEPTH];
   logic [IDX_W-1:0]           idx;

   // power-up contents differ at every index
   function automatic logic [31:0] fill_word(input int i);
      return {~i[15:0], i[15:0]} ^ 32'h5A3C_96E1;
   endfunction

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         words[i] = fill_word(i);
      end
   end

   assign idx         = iob_req_i.addr[IDX_W+1:2];
   // stall pattern comes from the testbench
   assign iob_ready_o = ready_i;

   always @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         iob_rvalid_o <= 1'b0;
         iob_rdata_o  <= '0;
      end else begin
         iob_rvalid_o <= 1'b0;
         if (iob_valid_i && iob_ready_o) begin
            if (iob_req_i.wstrb == '0) begin
               iob_rvalid_o <= 1'b1;
               iob_rdata_o  <= words[idx];
            end else begin
               for (int b = 0; b < `AXI2IOB_STRB_W; b++) begin
                  if (iob_req_i.wstrb[b]) begin
                     words[idx][8*b +: 8] <= iob_req_i.wdata[8*b +: 8];
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_axi2iob.sv
/*
 * AXI4 to IOb bridge testbench
 * drives write and read bursts, checks B and R against a reference memory
 */
`timescale 1ns/1ns
`default_nettype none
`include "axi2iob_macros.svh"

module tb_axi2iob;
   import axi2iob_pkg::*;

   localparam int TIMEOUT   = 2000;
   localparam int MEM_WORDS = 1024;

   logic       clk_i;
   logic       arst_i;
   axi_aw_t    aw_i;
   logic       aw_valid_i;
   logic       aw_ready_o;
   axi_w_t     w_i;
   logic       w_valid_i;
   logic       w_ready_o;
   axi_b_t     b_o;
   logic       b_valid_o;
   logic       b_ready_i;
   axi_aw_t    ar_i;
   logic       ar_valid_i;
   logic       ar_ready_o;
   axi_r_t     r_o;
   logic       r_valid_o;
   logic       r_ready_i;
   iob_req_t   iob_req;
   logic       iob_valid;
   logic       iob_ready;
   logic       iob_rvalid;
   iob_rdata_t iob_rdata;
   logic       mem_ready;

   // reference copy of the IOb memory
   logic [31:0] ref_mem [MEM_WORDS];
   axi_w_t      wr_data [256];
   axi_b_t      exp_b [$];
   axi_r_t      exp_r [$];
   axi_b_t      exp_b_head;
   axi_r_t      exp_r_head;
   iob_req_t    exp_iob_wr [$];
   iob_req_t    exp_iob_rd [$];
   iob_req_t    exp_iob_head;
   iob_req_t    iob_got;
   int          b_seen   = 0;
   int          r_seen   = 0;
   int          b_issued = 0;
   int          r_issued = 0;
   logic [15:0] data_lfsr;
   logic [15:0] stall_lfsr;
   logic        stall_en;
   int          b_hold;
   int          r_hold;
   axi_aw_t     wcmd;
   axi_aw_t     rcmd;

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   axi2iob_top dut0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .aw_i        (aw_i),
      .aw_valid_i  (aw_valid_i),
      .aw_ready_o  (aw_ready_o),
      .w_i         (w_i),
      .w_valid_i   (w_valid_i),
      .w_ready_o   (w_ready_o),
      .b_o         (b_o),
      .b_valid_o   (b_valid_o),
      .b_ready_i   (b_ready_i),
      .ar_i        (ar_i),
      .ar_valid_i  (ar_valid_i),
      .ar_ready_o  (ar_ready_o),
      .r_o         (r_o),
      .r_valid_o   (r_valid_o),
      .r_ready_i   (r_ready_i),
      .iob_req_o   (iob_req),
      .iob_valid_o (iob_valid),
      .iob_ready_i (iob_ready),
      .iob_rvalid_i(iob_rvalid),
      .iob_rdata_i (iob_rdata)
   );

   tb_iob_mem #(.DEPTH(MEM_WORDS)) mem0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .ready_i     (mem_ready),
      .iob_req_i   (iob_req),
      .iob_valid_i (iob_valid),
      .iob_ready_o (iob_ready),
      .iob_rvalid_o(iob_rvalid),
      .iob_rdata_o (iob_rdata)
   );

   task automatic stop_run();
      $display("Something failed");
      $fatal(1, "stopping at the first error");
   endtask

   // 16-bit Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         data_lfsr = lfsr_next(data_lfsr);
         v = {v[30:0], data_lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] initial_word(input int i);
      return {~i[15:0], i[15:0]} ^ 32'h5A3C_96E1;
   endfunction

   // each beat of an incrementing burst moves by 2**size bytes
   function automatic logic [31:0] beat_addr(input axi_aw_t cmd, input int beat);
      return cmd.addr + (32'(beat) << cmd.size);
   endfunction

   function automatic int word_index(input logic [31:0] addr);
      return int'(addr[11:2]);
   endfunction

   function automatic logic [3:0] lane_strb(input axi_aw_t cmd, input int beat);
      logic [31:0] a;
      a = beat_addr(cmd, beat);
      case (cmd.size)
         3'd0:    return 4'b0001 << a[1:0];
         3'd1:    return 4'b0011 << {a[1], 1'b0};
         default: return 4'b1111;
      endcase
   endfunction

   function automatic void ref_write(input axi_aw_t cmd, input int beat, input axi_w_t w);
      int idx;
      idx = word_index(beat_addr(cmd, beat));
      for (int b = 0; b < 4; b++) begin
         if (w.strb[b]) begin
            ref_mem[idx][8*b +: 8] = w.data[8*b +: 8];
         end
      end
   endfunction

   function automatic axi_r_t ref_read(input axi_aw_t cmd, input int beat);
      axi_r_t r;
      r.id   = cmd.id;
      r.data = ref_mem[word_index(beat_addr(cmd, beat))];
      r.last = (beat == int'(cmd.len));
      return r;
   endfunction

   function automatic void fill_beats(input axi_aw_t cmd);
      for (int i = 0; i <= int'(cmd.len); i++) begin
         wr_data[i].data = rand_bits(32);
         wr_data[i].strb = lane_strb(cmd, i);
         wr_data[i].last = (i == int'(cmd.len));
      end
   endfunction

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_b(input axi_b_t got, input axi_b_t exp);
      if (got !== exp) begin
         $display("ERR b_o.id got %h expected %h", got.id, exp.id);
         stop_run();
      end
   endtask

   task automatic check_r(input axi_r_t got, input axi_r_t exp);
      if (got !== exp) begin
         $display("ERR r_o got id %h data %h last %h, expected id %h data %h last %h",
                  got.id, got.data, got.last, exp.id, exp.data, exp.last);
         stop_run();
      end
   endtask

   task automatic check_iob(input iob_req_t got, input iob_req_t exp);
      if (got !== exp) begin
         $display("ERR iob_req_o got addr %h data %h strb %h expected addr %h data %h strb %h",
                  got.addr, got.wdata, got.wstrb, exp.addr, exp.wdata, exp.wstrb);
         stop_run();
      end
   endtask

   task automatic check_quiet();
      check_flag("aw_ready_o", aw_ready_o, 1'b0);
      check_flag("w_ready_o", w_ready_o, 1'b0);
      check_flag("b_valid_o", b_valid_o, 1'b0);
      check_flag("ar_ready_o", ar_ready_o, 1'b0);
      check_flag("r_valid_o", r_valid_o, 1'b0);
      check_flag("iob_valid_o", iob_valid, 1'b0);
   endtask

   task automatic do_write(input axi_aw_t cmd);
      int       t;
      int       target;
      axi_b_t   b;
      iob_req_t req;
      b.id = cmd.id;
      exp_b.push_back(b);
      b_issued++;
      target = b_issued;
      // beats without strobes must not show up on the IOb bus
      for (int i = 0; i <= int'(cmd.len); i++) begin
         if (wr_data[i].strb != '0) begin
            req.addr  = beat_addr(cmd, i);
            req.wdata = wr_data[i].data;
            req.wstrb = wr_data[i].strb;
            exp_iob_wr.push_back(req);
         end
      end
      @(negedge clk_i);
      aw_i       = cmd;
      aw_valid_i = 1'b1;
      t = 0;
      @(posedge clk_i);
      while (!aw_ready_o) begin
         t++;
         if (t > TIMEOUT) begin
            $display("timeout, the AW handshake never came");
            stop_run();
         end
         @(posedge clk_i);
      end
      for (int i = 0; i <= int'(cmd.len); i++) begin
         @(negedge clk_i);
         aw_valid_i = 1'b0;
         w_i        = wr_data[i];
         w_valid_i  = 1'b1;
         t = 0;
         @(posedge clk_i);
         while (!w_ready_o) begin
            t++;
            if (t > TIMEOUT) begin
               $display("timeout, W beat %0d was never accepted", i);
               stop_run();
            end
            @(posedge clk_i);
         end
         ref_write(cmd, i, wr_data[i]);
      end
      @(negedge clk_i);
      w_valid_i = 1'b0;
      t = 0;
      while (b_seen < target) begin
         t++;
         if (t > TIMEOUT) begin
            $display("timeout, the B response never came");
            stop_run();
         end
         @(negedge clk_i);
      end
   endtask

   task automatic do_read(input axi_aw_t cmd);
      int       t;
      int       target;
      iob_req_t req;
      for (int i = 0; i <= int'(cmd.len); i++) begin
         exp_r.push_back(ref_read(cmd, i));
         req.addr  = beat_addr(cmd, i);
         req.wdata = '0;
         req.wstrb = '0;
         exp_iob_rd.push_back(req);
      end
      r_issued += int'(cmd.len) + 1;
      target = r_issued;
      @(negedge clk_i);
      ar_i       = cmd;
      ar_valid_i = 1'b1;
      t = 0;
      @(posedge clk_i);
      while (!ar_ready_o) begin
         t++;
         if (t > TIMEOUT) begin
            $display("timeout, the AR handshake never came");
            stop_run();
         end
         @(posedge clk_i);
      end
      @(negedge clk_i);
      ar_valid_i = 1'b0;
      t = 0;
      while (r_seen < target) begin
         t++;
         if (t > TIMEOUT) begin
            $display("timeout, not all R beats of the burst came");
            stop_run();
         end
         @(negedge clk_i);
      end
   endtask

   // IOb stalls and B/R back-pressure change on the falling edge
   initial begin
      stall_lfsr = 16'd91;
      stall_en   = 1'b0;
      b_hold     = 0;
      r_hold     = 0;
      mem_ready  = 1'b1;
      b_ready_i  = 1'b1;
      r_ready_i  = 1'b1;
      forever begin
         @(negedge clk_i);
         if (stall_en) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            mem_ready  = stall_lfsr[0];
         end else begin
            mem_ready = 1'b1;
         end
         b_ready_i = (b_hold == 0);
         r_ready_i = (r_hold == 0);
         if (b_hold > 0) begin
            b_hold--;
         end
         if (r_hold > 0) begin
            r_hold--;
         end
      end
   end

   // every B, R and IOb handshake against the expected queues
   always @(posedge clk_i) begin
      if (!arst_i && b_valid_o && b_ready_i) begin
         if (exp_b.size() == 0) begin
            $display("a B response came with no write burst outstanding");
            stop_run();
         end else begin
            exp_b_head = exp_b.pop_front();
            check_b(b_o, exp_b_head);
            b_seen++;
         end
      end
      if (!arst_i && r_valid_o && r_ready_i) begin
         if (exp_r.size() == 0) begin
            $display("an R beat came with no read beat expected");
            stop_run();
         end else begin
            exp_r_head = exp_r.pop_front();
            check_r(r_o, exp_r_head);
            r_seen++;
         end
      end
      if (!arst_i && iob_valid && iob_ready) begin
         iob_got = iob_req;
         if (iob_req.wstrb == '0) begin
            // write data means nothing on an IOb read
            iob_got.wdata = '0;
            if (exp_iob_rd.size() == 0) begin
               $display("an IOb read was issued with no read beat expected");
               stop_run();
            end else begin
               exp_iob_head = exp_iob_rd.pop_front();
               check_iob(iob_got, exp_iob_head);
            end
         end else begin
            if (exp_iob_wr.size() == 0) begin
               $display("an IOb write was issued with no strobed beat expected");
               stop_run();
            end else begin
               exp_iob_head = exp_iob_wr.pop_front();
               check_iob(iob_got, exp_iob_head);
            end
         end
      end
   end

   initial begin
      arst_i     = 1'b1;
      aw_i       = '0;
      aw_valid_i = 1'b0;
      w_i        = '0;
      w_valid_i  = 1'b0;
      ar_i       = '0;
      ar_valid_i = 1'b0;
      data_lfsr  = 16'd91;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = initial_word(i);
      end

      repeat (16) begin
         @(negedge clk_i);
         check_quiet();
      end
      arst_i = 1'b0;
      check_quiet();

      // single beat write then read back
      wcmd = '{id: 8'h11, addr: 32'h040, len: 8'd0, size: 3'd2};
      fill_beats(wcmd);
      do_write(wcmd);
      do_read('{id: 8'h22, addr: 32'h040, len: 8'd0, size: 3'd2});

      // 8 beats of full words
      wcmd = '{id: 8'h03, addr: 32'h080, len: 8'd7, size: 3'd2};
      fill_beats(wcmd);
      do_write(wcmd);
      do_read('{id: 8'h04, addr: 32'h080, len: 8'd7, size: 3'd2});

      // partial strobes and two beats with no strobe at all
      wcmd = '{id: 8'h05, addr: 32'h100, len: 8'd5, size: 3'd2};
      fill_beats(wcmd);
      wr_data[0].strb = 4'b0011;
      wr_data[1].strb = 4'b0000;
      wr_data[2].strb = 4'b1100;
      wr_data[3].strb = 4'b0101;
      wr_data[4].strb = 4'b0000;
      wr_data[5].strb = 4'b1000;
      do_write(wcmd);
      do_read('{id: 8'h06, addr: 32'h100, len: 8'd5, size: 3'd2});

      // narrow bursts in byte then halfword steps
      wcmd = '{id: 8'h07, addr: 32'h201, len: 8'd7, size: 3'd0};
      fill_beats(wcmd);
      do_write(wcmd);
      do_read('{id: 8'h08, addr: 32'h201, len: 8'd7, size: 3'd0});
      do_read('{id: 8'h09, addr: 32'h200, len: 8'd2, size: 3'd2});
      wcmd = '{id: 8'h0A, addr: 32'h302, len: 8'd5, size: 3'd1};
      fill_beats(wcmd);
      do_write(wcmd);
      do_read('{id: 8'h0B, addr: 32'h302, len: 8'd5, size: 3'd1});
      do_read('{id: 8'h0C, addr: 32'h300, len: 8'd3, size: 3'd2});

      // write and read together under IOb stalls and held B/R ready
      wcmd = '{id: 8'h0D, addr: 32'h400, len: 8'd15, size: 3'd2};
      rcmd = '{id: 8'h0E, addr: 32'h800, len: 8'd15, size: 3'd2};
      fill_beats(wcmd);
      @(posedge clk_i);
      stall_en = 1'b1;
      b_hold   = 60;
      r_hold   = 30;
      fork
         do_write(wcmd);
         do_read(rcmd);
      join
      do_read('{id: 8'h0F, addr: 32'h400, len: 8'd15, size: 3'd2});

      repeat (4) @(negedge clk_i);
      if (exp_b.size() == 0 && exp_r.size() == 0 &&
          exp_iob_wr.size() == 0 && exp_iob_rd.size() == 0 &&
          b_seen == b_issued && r_seen == r_issued) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("some B, R or IOb transfers were still missing at the end");
         stop_run();
      end
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
axi2iob_pkg.sv
axi2iob_write_burst.sv
axi2iob_read_burst.sv
iob_bus_arbiter.sv
axi2iob_top.sv
tb_iob_mem.sv
tb_axi2iob.sv

// File: run_sim.sh
#!/bin/sh
# build and run the AXI4 to IOb bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi2iob \
   -f filelist.f -o sim_axi2iob > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_axi2iob > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Everything OK$" sim.log; then
   exit 0
else
   echo "pass line not found in sim.log"
   exit 1
fi
